// File: source/fmap_pkg.sv
package fmap_pkg;

	// external memory address width
	localparam int AW = 32;

	// external memory data width, one feature word per beat
	localparam int DW = 32;

	// width shared by every walk counter in the fetch path
	localparam int CW = 8;

	// address walker states
	// idle until the first start pulse, done once the last burst of the map is queued
	typedef enum logic [1:0] {
		GEN_IDLE = 2'd0,
		GEN_RUN  = 2'd1,
		GEN_DONE = 2'd2
	} gen_state_e;

	// arburst carries the burst length as its log2 code
	// a length that is not a power of two rounds up
	function automatic logic [3:0] burst_code(input int unsigned len);
		logic [3:0] code;
		code = 4'd0;
		for (int i = 0; i < 15; i++) begin
			// every power of two still below len adds one to the code
			if ((32'd1 << i) < len) begin
				code = 4'(i + 1);
			end
		end
		return code;
	endfunction

endpackage

// File: source/tile_addr_gen.sv
module tile_addr_gen #(
	parameter int KSIZE  = 3,
	parameter int POX    = 4,
	parameter int POY    = 2,
	parameter int STRIDE = 2,
	parameter int IW     = 32,
	parameter int IH     = 16,
	parameter int BURST  = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// start pulse with the map base address
	input  logic                    init_addr_en,
	input  logic [fmap_pkg::AW-1:0] init_addr,
	// queue level that holds back every push while high
	input  logic                    queue_full,
	// last beat of the map seen by the unpacker ends busy
	input  logic                    mapend,
	output logic [fmap_pkg::AW-1:0] burst_addr,
	output logic                    burst_push,
	output logic                    busy
);

// rows of one tile and words of one tile row
localparam int LM   = (STRIDE + 1) * POY - STRIDE;
localparam int BUFW = POX * STRIDE;
// bursts per tile row and tiles per row of tiles
localparam int BPR  = BUFW / BURST;
localparam int TPR  = IW / BUFW;
// output rows of the convolution are covered POY at a time
localparam int OH    = (IH - KSIZE) / STRIDE + 1;
localparam int TROWS = (OH + POY - 1) / POY;

// last value of each counter
localparam int BPR_M1   = BPR - 1;
localparam int LM_M1    = LM - 1;
localparam int TPR_M1   = TPR - 1;
localparam int TROWS_M1 = TROWS - 1;
localparam logic [fmap_pkg::CW-1:0] BURST_LAST = BPR_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] ROW_LAST   = LM_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] TILE_LAST  = TPR_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] TROW_LAST  = TROWS_M1[fmap_pkg::CW-1:0];

// address steps of the four loops
localparam logic [fmap_pkg::AW-1:0] BURST_STEP = BURST;
localparam logic [fmap_pkg::AW-1:0] ROW_STEP   = IW;
localparam logic [fmap_pkg::AW-1:0] TILE_STEP  = BUFW;
localparam logic [fmap_pkg::AW-1:0] TROW_STEP  = POY * STRIDE * IW;

fmap_pkg::gen_state_e state;

logic [fmap_pkg::CW-1:0] burst_cnt;
logic [fmap_pkg::CW-1:0] row_cnt;
logic [fmap_pkg::CW-1:0] tile_cnt;
logic [fmap_pkg::CW-1:0] trow_cnt;

// current burst, start of the current row, tile and tile row
logic [fmap_pkg::AW-1:0] addr_r;
logic [fmap_pkg::AW-1:0] row_addr_r;
logic [fmap_pkg::AW-1:0] tile_addr_r;
logic [fmap_pkg::AW-1:0] trow_addr_r;

logic last_burst;
logic last_row;
logic last_tile;
logic last_trow;

assign last_burst = (burst_cnt == BURST_LAST);
assign last_row   = (row_cnt == ROW_LAST);
assign last_tile  = (tile_cnt == TILE_LAST);
assign last_trow  = (trow_cnt == TROW_LAST);

// one address per cycle while running and the queue has room
assign burst_push = (state == fmap_pkg::GEN_RUN) && !queue_full;
assign burst_addr = addr_r;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= fmap_pkg::GEN_IDLE;
	end else if (init_addr_en) begin
		// a start pulse restarts the walk from any state
		state <= fmap_pkg::GEN_RUN;
	end else if (burst_push && last_burst && last_row && last_tile && last_trow) begin
		state <= fmap_pkg::GEN_DONE;
	end
end

// nested loop counters with the burst within a row innermost
always_ff @(posedge clk) begin
	if (!rst_n || init_addr_en) begin
		burst_cnt <= '0;
		row_cnt   <= '0;
		tile_cnt  <= '0;
		trow_cnt  <= '0;
	end else if (burst_push) begin
		burst_cnt <= last_burst ? '0 : burst_cnt + 1'b1;
		if (last_burst) begin
			row_cnt <= last_row ? '0 : row_cnt + 1'b1;
			if (last_row) begin
				tile_cnt <= last_tile ? '0 : tile_cnt + 1'b1;
				if (last_tile) begin
					trow_cnt <= last_trow ? '0 : trow_cnt + 1'b1;
				end
			end
		end
	end
end

// each wrap restarts from the start address of the enclosing loop
always_ff @(posedge clk) begin
	if (init_addr_en) begin
		addr_r      <= init_addr;
		row_addr_r  <= init_addr;
		tile_addr_r <= init_addr;
		trow_addr_r <= init_addr;
	end else if (burst_push) begin
		if (!last_burst) begin
			addr_r <= addr_r + BURST_STEP;
		end else if (!last_row) begin
			addr_r     <= row_addr_r + ROW_STEP;
			row_addr_r <= row_addr_r + ROW_STEP;
		end else if (!last_tile) begin
			addr_r      <= tile_addr_r + TILE_STEP;
			row_addr_r  <= tile_addr_r + TILE_STEP;
			tile_addr_r <= tile_addr_r + TILE_STEP;
		end else if (!last_trow) begin
			// next tile row starts POY*STRIDE map rows further down
			addr_r      <= trow_addr_r + TROW_STEP;
			row_addr_r  <= trow_addr_r + TROW_STEP;
			tile_addr_r <= trow_addr_r + TROW_STEP;
			trow_addr_r <= trow_addr_r + TROW_STEP;
		end
	end
end

// busy spans the whole map, up to the last returned beat
always_ff @(posedge clk) begin
	if (!rst_n) begin
		busy <= 1'b0;
	end else if (init_addr_en) begin
		busy <= 1'b1;
	end else if (mapend) begin
		busy <= 1'b0;
	end
end

// tile rows must split into whole bursts and rows into whole tiles
if ((BUFW % BURST) != 0 || (IW % BUFW) != 0) begin : g_geom_check
	$error("tile width must be a multiple of BURST and IW a multiple of tile width");
end

// the unpacker counts the same geometry so the map ends after the walk
a_mapend_after_walk: assert property (@(posedge clk) disable iff (!rst_n)
	mapend |-> (state == fmap_pkg::GEN_DONE));

endmodule

// File: source/burst_req_queue.sv
module burst_req_queue #(
	parameter int BURST   = 4,
	parameter int MAX_OUT = 3
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// burst addresses from the walker
	input  logic [fmap_pkg::AW-1:0] burst_addr,
	input  logic                    burst_push,
	// read response strobes where rlast retires one burst
	input  logic                    rvalid,
	input  logic                    rlast,
	output logic                    queue_full,
	output logic [fmap_pkg::AW-1:0] araddr,
	output logic                    arvalid,
	output logic [3:0]              arburst
);

// outstanding count holds 0 to MAX_OUT
localparam int OW = $clog2(MAX_OUT + 1);
localparam logic [OW-1:0] OUT_MAX = MAX_OUT[OW-1:0];

// two entry address FIFO
logic [fmap_pkg::AW-1:0] fifo_mem [2];
logic                    wr_ptr;
logic                    rd_ptr;
logic [1:0]              fill;

// bursts requested and not yet closed by rlast
logic [OW-1:0] out_cnt;

logic issue;
logic retire;

// head goes out whenever memory may take one more burst
assign issue      = (fill != 2'd0) && (out_cnt < OUT_MAX);
assign retire     = rvalid && rlast;
assign queue_full = (fill == 2'd2);

// fixed burst length for every request
assign arburst = fmap_pkg::burst_code(BURST);

always_ff @(posedge clk) begin
	if (burst_push) begin
		fifo_mem[wr_ptr] <= burst_addr;
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= 1'b0;
		rd_ptr <= 1'b0;
		fill   <= 2'd0;
	end else begin
		if (burst_push) begin
			wr_ptr <= ~wr_ptr;
		end
		if (issue) begin
			rd_ptr <= ~rd_ptr;
		end
		// push and pop in one cycle leave the fill level alone
		case ({burst_push, issue})
			2'b10:   fill <= fill + 2'd1;
			2'b01:   fill <= fill - 2'd1;
			default: fill <= fill;
		endcase
	end
end

// one cycle request pulse per burst
always_ff @(posedge clk) begin
	if (!rst_n) begin
		arvalid <= 1'b0;
	end else begin
		arvalid <= issue;
	end
end

always_ff @(posedge clk) begin
	if (issue) begin
		araddr <= fifo_mem[rd_ptr];
	end
end

// counted at the edge that raises arvalid so the next issue sees it
always_ff @(posedge clk) begin
	if (!rst_n) begin
		out_cnt <= '0;
	end else begin
		case ({issue, retire})
			2'b10:   out_cnt <= out_cnt + 1'b1;
			2'b01:   out_cnt <= out_cnt - 1'b1;
			default: out_cnt <= out_cnt;
		endcase
	end
end

// every burst closed by memory was requested earlier
a_rlast_has_req: assert property (@(posedge clk) disable iff (!rst_n)
	retire |-> (out_cnt != '0));

endmodule

// File: source/beat_unpacker.sv
module beat_unpacker #(
	parameter int KSIZE  = 3,
	parameter int POX    = 4,
	parameter int POY    = 2,
	parameter int STRIDE = 2,
	parameter int IW     = 32,
	parameter int IH     = 16,
	parameter int BURST  = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// start pulse, clears the walk
	input  logic                    init_addr_en,
	// in order read response beats
	input  logic                    rvalid,
	input  logic                    rlast,
	input  logic [fmap_pkg::DW-1:0] rdata,
	// line buffer write port
	output logic                    buf_we,
	output logic [fmap_pkg::CW-1:0] buf_row,
	output logic [fmap_pkg::CW-1:0] buf_col,
	output logic [fmap_pkg::DW-1:0] buf_data,
	output logic                    blkend,
	output logic                    mapend
);

// same tile geometry as the address walker
localparam int LM    = (STRIDE + 1) * POY - STRIDE;
localparam int BUFW  = POX * STRIDE;
localparam int TPR   = IW / BUFW;
localparam int OH    = (IH - KSIZE) / STRIDE + 1;
localparam int TROWS = (OH + POY - 1) / POY;

localparam int BURST_M1 = BURST - 1;
localparam int BUFW_M1  = BUFW - 1;
localparam int LM_M1    = LM - 1;
localparam int TPR_M1   = TPR - 1;
localparam int TROWS_M1 = TROWS - 1;
localparam logic [fmap_pkg::CW-1:0] BEAT_LAST = BURST_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] COL_LAST  = BUFW_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] ROW_LAST  = LM_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] TILE_LAST = TPR_M1[fmap_pkg::CW-1:0];
localparam logic [fmap_pkg::CW-1:0] TROW_LAST = TROWS_M1[fmap_pkg::CW-1:0];

// beat within a burst, column and row within a tile
logic [fmap_pkg::CW-1:0] beat_cnt;
logic [fmap_pkg::CW-1:0] col_cnt;
logic [fmap_pkg::CW-1:0] row_cnt;
// tile within a row of tiles, tile row within the map
logic [fmap_pkg::CW-1:0] tile_cnt;
logic [fmap_pkg::CW-1:0] trow_cnt;

logic tile_done;

// beat that closes the last row of a tile
assign tile_done = rvalid && rlast && (col_cnt == COL_LAST) && (row_cnt == ROW_LAST);

// write position comes straight from the registered counters
assign buf_we   = rvalid;
assign buf_row  = row_cnt;
assign buf_col  = col_cnt;
assign buf_data = rdata;

always_ff @(posedge clk) begin
	if (!rst_n || init_addr_en) begin
		beat_cnt <= '0;
		col_cnt  <= '0;
		row_cnt  <= '0;
		tile_cnt <= '0;
		trow_cnt <= '0;
	end else if (rvalid) begin
		beat_cnt <= (beat_cnt == BEAT_LAST) ? '0 : beat_cnt + 1'b1;
		col_cnt  <= (col_cnt == COL_LAST) ? '0 : col_cnt + 1'b1;
		// rows advance at the end of each tile row of BUFW beats
		if (col_cnt == COL_LAST) begin
			row_cnt <= (row_cnt == ROW_LAST) ? '0 : row_cnt + 1'b1;
			if (row_cnt == ROW_LAST) begin
				tile_cnt <= (tile_cnt == TILE_LAST) ? '0 : tile_cnt + 1'b1;
				if (tile_cnt == TILE_LAST) begin
					trow_cnt <= (trow_cnt == TROW_LAST) ? '0 : trow_cnt + 1'b1;
				end
			end
		end
	end
end

// end markers one cycle after the closing rlast
always_ff @(posedge clk) begin
	if (!rst_n) begin
		blkend <= 1'b0;
		mapend <= 1'b0;
	end else begin
		blkend <= tile_done;
		mapend <= tile_done && (tile_cnt == TILE_LAST) && (trow_cnt == TROW_LAST);
	end
end

// memory closes each burst after exactly BURST beats
a_rlast_align: assert property (@(posedge clk) disable iff (!rst_n)
	rvalid |-> (rlast == (beat_cnt == BEAT_LAST)));

endmodule

// File: source/fmap_fetch_top.sv
module fmap_fetch_top #(
	parameter int KSIZE   = 3,
	parameter int POX     = 4,
	parameter int POY     = 2,
	parameter int STRIDE  = 2,
	parameter int IW      = 32,
	parameter int IH      = 16,
	parameter int BURST   = 4,
	parameter int MAX_OUT = 3
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// map start
	input  logic                    init_addr_en,
	input  logic [fmap_pkg::AW-1:0] init_addr,
	// read response from memory
	input  logic                    rvalid,
	input  logic                    rlast,
	input  logic [fmap_pkg::DW-1:0] rdata,
	// read request to memory
	output logic [fmap_pkg::AW-1:0] araddr,
	output logic                    arvalid,
	output logic [3:0]              arburst,
	// tile line buffer write
	output logic                    buf_we,
	output logic [fmap_pkg::CW-1:0] buf_row,
	output logic [fmap_pkg::CW-1:0] buf_col,
	output logic [fmap_pkg::DW-1:0] buf_data,
	output logic                    blkend,
	output logic                    mapend,
	output logic                    busy
);

// walker to queue
logic [fmap_pkg::AW-1:0] burst_addr;
logic                    burst_push;
logic                    queue_full;

// walks the map and produces one burst address per cycle
tile_addr_gen #(
	.KSIZE  (KSIZE),
	.POX    (POX),
	.POY    (POY),
	.STRIDE (STRIDE),
	.IW     (IW),
	.IH     (IH),
	.BURST  (BURST)
) u_gen (
	.clk          (clk),
	.rst_n        (rst_n),
	.init_addr_en (init_addr_en),
	.init_addr    (init_addr),
	.queue_full   (queue_full),
	.mapend       (mapend),
	.burst_addr   (burst_addr),
	.burst_push   (burst_push),
	.busy         (busy)
);

// holds addresses until memory may take another burst
burst_req_queue #(
	.BURST   (BURST),
	.MAX_OUT (MAX_OUT)
) u_req (
	.clk        (clk),
	.rst_n      (rst_n),
	.burst_addr (burst_addr),
	.burst_push (burst_push),
	.rvalid     (rvalid),
	.rlast      (rlast),
	.queue_full (queue_full),
	.araddr     (araddr),
	.arvalid    (arvalid),
	.arburst    (arburst)
);

// places returned beats into the line buffer
beat_unpacker #(
	.KSIZE  (KSIZE),
	.POX    (POX),
	.POY    (POY),
	.STRIDE (STRIDE),
	.IW     (IW),
	.IH     (IH),
	.BURST  (BURST)
) u_unpack (
	.clk          (clk),
	.rst_n        (rst_n),
	.init_addr_en (init_addr_en),
	.rvalid       (rvalid),
	.rlast        (rlast),
	.rdata        (rdata),
	.buf_we       (buf_we),
	.buf_row      (buf_row),
	.buf_col      (buf_col),
	.buf_data     (buf_data),
	.blkend       (blkend),
	.mapend       (mapend)
);

endmodule

// File: sim/rd_mem_model.sv
module rd_mem_model #(
	parameter int          BURST = 4,
	parameter logic [31:0] SEED  = 32'h83a4_ac38
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// read request pulse from the DUT
	input  logic                    arvalid,
	input  logic [fmap_pkg::AW-1:0] araddr,
	// read response beats, data equals the beat address
	output logic                    rvalid,
	output logic                    rlast,
	output logic [fmap_pkg::DW-1:0] rdata,
	// requests taken and not yet closed by rlast
	output logic [7:0]              outstanding
);

integer seed;

// accepted requests, served strictly in order
logic [fmap_pkg::AW-1:0] req_q [$];

logic                    active;
logic [fmap_pkg::AW-1:0] cur_addr;
int                      delay;
int                      beat;

initial begin
	seed        = SEED;
	rvalid      = 1'b0;
	rlast       = 1'b0;
	rdata       = '0;
	outstanding = '0;
	active      = 1'b0;
	cur_addr    = '0;
	delay       = 0;
	beat        = 0;
end

// requests are taken on the rising edge, like any memory slave
always @(posedge clk) begin
	if (!rst_n) begin
		req_q.delete();
		outstanding <= '0;
	end else begin
		if (arvalid) begin
			req_q.push_back(araddr);
		end
		case ({arvalid, rvalid && rlast})
			2'b10:   outstanding <= outstanding + 8'd1;
			2'b01:   outstanding <= outstanding - 8'd1;
			default: outstanding <= outstanding;
		endcase
	end
end

// responses change on the falling edge
always @(negedge clk) begin
	rvalid = 1'b0;
	rlast  = 1'b0;
	if (!rst_n) begin
		active = 1'b0;
	end else if (!active) begin
		if (req_q.size() != 0) begin
			// start of a burst, random latency of 0 to 7 cycles
			cur_addr = req_q.pop_front();
			delay    = $random(seed) & 7;
			beat     = 0;
			active   = 1'b1;
		end
	end else if (delay > 0) begin
		delay = delay - 1;
	end else if (($random(seed) & 3) != 0) begin
		// roughly one cycle in four is a gap between beats
		rvalid = 1'b1;
		rdata  = cur_addr + beat;
		rlast  = (beat == BURST - 1);
		if (beat == BURST - 1) begin
			active = 1'b0;
		end
		beat = beat + 1;
	end
end

endmodule

// File: sim/fmap_fetch_tb.sv
module fmap_fetch_tb;

localparam int KSIZE   = 3;
localparam int POX     = 4;
localparam int POY     = 2;
localparam int STRIDE  = 2;
localparam int IW      = 32;
localparam int IH      = 16;
localparam int BURST   = 4;
localparam int MAX_OUT = 3;
localparam logic [31:0] SEED = 32'h83a4_ac38;

// tile geometry of LM rows by BUFW words
localparam int BUFW  = POX * STRIDE;
localparam int LM    = (STRIDE + 1) * POY - STRIDE;
localparam int BPR   = BUFW / BURST;
localparam int TPR   = IW / BUFW;
// tile rows step POY*STRIDE map rows at a time
localparam int TROWS = IH / (POY * STRIDE);
localparam int BURSTS_PER_MAP = BPR * LM * TPR * TROWS;
localparam int TILES_PER_MAP  = TPR * TROWS;
localparam int TILE_BEATS     = LM * BUFW;
localparam int MAP_BEATS      = BURSTS_PER_MAP * BURST;
// quiet cycles after mapend in which no request may appear
localparam int QUIET_CYCLES   = 40;
// two maps at about 20 cycles per burst plus margin
localparam int TIMEOUT_CYCLES = 8000;

logic                    clk;
logic                    rst_n;
logic                    init_addr_en;
logic [fmap_pkg::AW-1:0] init_addr;
logic                    rvalid;
logic                    rlast;
logic [fmap_pkg::DW-1:0] rdata;
logic [fmap_pkg::AW-1:0] araddr;
logic                    arvalid;
logic [3:0]              arburst;
logic                    buf_we;
logic [fmap_pkg::CW-1:0] buf_row;
logic [fmap_pkg::CW-1:0] buf_col;
logic [fmap_pkg::DW-1:0] buf_data;
logic                    blkend;
logic                    mapend;
logic                    busy;
logic [7:0]              outstanding;

integer seed;
string  map_name;
int     cycle_cnt;
// expected requests and beats of the current map in walk order
logic [fmap_pkg::AW-1:0] exp_ar [$];
logic [fmap_pkg::DW-1:0] exp_data [$];
int                      exp_row [$];
int                      exp_col [$];
// observed activity of the current map
int   ar_cnt;
int   beat_cnt;
int   blk_cnt;
int   map_cnt;
logic blk_due;
logic map_due;
logic [fmap_pkg::AW-1:0] base;

fmap_fetch_top #(
	.KSIZE   (KSIZE),
	.POX     (POX),
	.POY     (POY),
	.STRIDE  (STRIDE),
	.IW      (IW),
	.IH      (IH),
	.BURST   (BURST),
	.MAX_OUT (MAX_OUT)
) dut0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.init_addr_en (init_addr_en),
	.init_addr    (init_addr),
	.rvalid       (rvalid),
	.rlast        (rlast),
	.rdata        (rdata),
	.araddr       (araddr),
	.arvalid      (arvalid),
	.arburst      (arburst),
	.buf_we       (buf_we),
	.buf_row      (buf_row),
	.buf_col      (buf_col),
	.buf_data     (buf_data),
	.blkend       (blkend),
	.mapend       (mapend),
	.busy         (busy)
);

rd_mem_model #(
	.BURST (BURST),
	.SEED  (SEED)
) u_mem (
	.clk         (clk),
	.rst_n       (rst_n),
	.arvalid     (arvalid),
	.araddr      (araddr),
	.rvalid      (rvalid),
	.rlast       (rlast),
	.rdata       (rdata),
	.outstanding (outstanding)
);

initial begin
	clk = 1'b0;
end

always #50 clk = ~clk;

task automatic stop_failed();
	fmap_pkg::gen_state_e st;
	st = dut0.u_gen.state;
	$display("walker state %s at cycle %0d", st.name(), cycle_cnt);
	$display("sim failed");
	$fatal(1);
endtask

task automatic report_error(input string msg);
	$display("%s", msg);
	stop_failed();
endtask

task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
	if (expected !== actual) begin
		$display("CHECK FAILED %s %s expected %0h actual %0h", map_name, what, expected, actual);
		stop_failed();
	end
endtask

// reference walk over tile rows, tiles, rows within a tile and bursts within a row
task automatic build_expected(input logic [fmap_pkg::AW-1:0] map_base);
	logic [fmap_pkg::AW-1:0] a;
	for (int tr = 0; tr < TROWS; tr++) begin
		for (int t = 0; t < TPR; t++) begin
			for (int r = 0; r < LM; r++) begin
				for (int b = 0; b < BPR; b++) begin
					a = map_base + (tr * POY * STRIDE + r) * IW + t * BUFW + b * BURST;
					exp_ar.push_back(a);
					for (int k = 0; k < BURST; k++) begin
						exp_data.push_back(a + k);
						exp_row.push_back(r);
						exp_col.push_back(b * BURST + k);
					end
				end
			end
		end
	end
endtask

// one whole map from the start pulse to the quiet period after mapend
task automatic run_map(input string name, input logic [fmap_pkg::AW-1:0] map_base);
	map_name = name;
	build_expected(map_base);
	@(negedge clk);
	ar_cnt       = 0;
	beat_cnt     = 0;
	blk_cnt      = 0;
	map_cnt      = 0;
	init_addr_en = 1'b1;
	init_addr    = map_base;
	@(negedge clk);
	init_addr_en = 1'b0;
	wait (map_cnt == 1);
	@(negedge clk);
	check_value("busy after mapend", 0, busy);
	repeat (QUIET_CYCLES) @(negedge clk);
	check_value("request count", BURSTS_PER_MAP, ar_cnt);
	check_value("requests left", 0, exp_ar.size());
	check_value("beats left", 0, exp_data.size());
	check_value("blkend count", TILES_PER_MAP, blk_cnt);
	check_value("mapend count", 1, map_cnt);
	check_value("busy when idle", 0, busy);
endtask

// monitor sampling on the rising edge
always @(posedge clk) begin
	if (rst_n) begin
		// end markers lag the closing beat by one cycle
		check_value("blkend", blk_due, blkend);
		check_value("mapend", map_due, mapend);
		if (blkend) begin
			blk_cnt = blk_cnt + 1;
		end
		if (mapend) begin
			map_cnt = map_cnt + 1;
		end
		check_value("outstanding limit", 1, (outstanding <= MAX_OUT));
		if (arvalid) begin
			ar_cnt = ar_cnt + 1;
			if (exp_ar.size() == 0) begin
				report_error("read request seen after the last burst of the map");
			end else begin
				check_value("araddr", exp_ar.pop_front(), araddr);
				check_value("arburst", $clog2(BURST), arburst);
				check_value("busy during requests", 1, busy);
			end
		end
		blk_due = 1'b0;
		map_due = 1'b0;
		if (buf_we) begin
			if (exp_data.size() == 0) begin
				report_error("line buffer write seen after the last beat of the map");
			end else begin
				check_value("buf_data", exp_data.pop_front(), buf_data);
				check_value("buf_row", exp_row.pop_front(), buf_row);
				check_value("buf_col", exp_col.pop_front(), buf_col);
			end
			beat_cnt = beat_cnt + 1;
			blk_due  = ((beat_cnt % TILE_BEATS) == 0);
			map_due  = (beat_cnt == MAP_BEATS);
			if (blk_due) begin
				check_value("rlast at tile end", 1, rlast);
			end
		end
	end
end

// run limit over both maps
always @(posedge clk) begin
	cycle_cnt = cycle_cnt + 1;
	if (cycle_cnt >= TIMEOUT_CYCLES) begin
		report_error("timeout before mapend");
	end
end

initial begin
	seed         = SEED;
	cycle_cnt    = 0;
	map_name     = "reset";
	rst_n        = 1'b0;
	init_addr_en = 1'b0;
	init_addr    = '0;
	ar_cnt       = 0;
	beat_cnt     = 0;
	blk_cnt      = 0;
	map_cnt      = 0;
	blk_due      = 1'b0;
	map_due      = 1'b0;
	repeat (5) @(negedge clk);
	rst_n = 1'b1;
	repeat (2) @(negedge clk);
	// random word-aligned bases kept low so that no address wraps
	base = $random(seed) & 32'h00ff_fff0;
	run_map("map0", base);
	base = $random(seed) & 32'h00ff_fff0;
	run_map("map1", base);
	$display("sim passed");
	$finish;
end

endmodule

// File: sources.f
source/fmap_pkg.sv
source/tile_addr_gen.sv
source/burst_req_queue.sv
source/beat_unpacker.sv
source/fmap_fetch_top.sv
sim/rd_mem_model.sv
sim/fmap_fetch_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := fmap_fetch_tb
RTL_TOP    := fmap_fetch_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
